/* rtl/alu_cluster_pkg.sv */
// Shared sizes, ALU operation codes and packet types for the ALU cluster.
// Every design file refers to these through alu_cluster_pkg:: names.

package alu_cluster_pkg;

    ////////////////////////////////////////
    // Sizes

    localparam int NUM_LANES  = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int XLEN       = 32;
    localparam int ID_W       = 4;
    localparam int RD_W       = 5;

    // Derived index widths
    localparam int LANE_IDX_W = $clog2(NUM_LANES);
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // Shift amount comes from the low bits of operand b
    localparam int SHAMT_W = 5;

    ////////////////////////////////////////
    // Operation encoding

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_t;

    ////////////////////////////////////////
    // Packets

    // Issue side, 77 bits
    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [RD_W-1:0] rd;
        alu_op_t         op;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
    } issue_packet_t;

    // Writeback side, 41 bits
    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [RD_W-1:0] rd;
        logic [XLEN-1:0] data;
    } wb_packet_t;

endpackage

/* rtl/packet_fifo.sv */
// Small synchronous FIFO for packet streams, payload type set per instance.
// Push only while push_ready is high, pop only while pop_valid is high.

`timescale 1ns/1ps

module packet_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     push,
    input  payload_t push_data,
    output logic     push_ready,

    input  logic     pop,
    output payload_t pop_data,
    output logic     pop_valid
);

    payload_t mem [alu_cluster_pkg::FIFO_DEPTH];

    logic [alu_cluster_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [alu_cluster_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [alu_cluster_pkg::FIFO_CNT_W-1:0] count;

    // Wraps at the buffer depth, which need not be a power of two
    function automatic logic [alu_cluster_pkg::FIFO_PTR_W-1:0] next_ptr(
        input logic [alu_cluster_pkg::FIFO_PTR_W-1:0] ptr
    );
        if (ptr == alu_cluster_pkg::FIFO_PTR_W'(alu_cluster_pkg::FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    ////////////////////////////////////////
    // Pointers and fill level

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign push_ready = (count != alu_cluster_pkg::FIFO_CNT_W'(alu_cluster_pkg::FIFO_DEPTH));
    assign pop_valid  = (count != '0);
    // Head is visible the cycle after it was written
    assign pop_data   = mem[rd_ptr];

    ////////////////////////////////////////
    // Checks

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> push_ready
    );

    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> pop_valid
    );

endmodule

/* rtl/issue_dispatch.sv */
// Takes the head issue packet and sends it to the lowest-numbered idle lane.
// Dispatch happens in the cycle the head is visible, if any lane is free.

`timescale 1ns/1ps

module issue_dispatch (
    input  logic                                       clk,
    input  logic                                       rst_n,

    input  alu_cluster_pkg::issue_packet_t             head,
    input  logic                                       head_valid,
    output logic                                       pop,

    input  logic [alu_cluster_pkg::NUM_LANES-1:0]      busy,

    output logic [alu_cluster_pkg::NUM_LANES-1:0]      issue_valid,
    output alu_cluster_pkg::issue_packet_t             issue_packet
);

    logic [alu_cluster_pkg::NUM_LANES-1:0] idle_sel;
    logic                                  any_idle;

    ////////////////////////////////////////
    // Lowest idle lane

    always_comb begin
        logic found;
        found    = 1'b0;
        idle_sel = '0;
        for (int i = 0; i < alu_cluster_pkg::NUM_LANES; i++) begin
            if (!busy[i] && !found) begin
                idle_sel[i] = 1'b1;
                found       = 1'b1;
            end
        end
        any_idle = found;
    end

    // Only the selected lane sees a valid, all lanes share the packet bus
    assign issue_valid  = head_valid ? idle_sel : '0;
    assign issue_packet = head;
    assign pop          = head_valid & any_idle;

    ////////////////////////////////////////
    // Checks

    a_issue_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(issue_valid)
    );

    // busy comes back from the lanes, so this covers the lane side too
    a_issue_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n) (issue_valid & busy) == '0
    );

endmodule

/* rtl/alu_lane.sv */
// One RV32I integer ALU lane. Computes on issue and holds the tagged result
// until the writeback arbiter grants it.

`timescale 1ns/1ps

module alu_lane (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           issue_valid,
    input  alu_cluster_pkg::issue_packet_t issue_packet,

    output logic                           busy,
    output logic                           done,
    output alu_cluster_pkg::wb_packet_t    result,

    input  logic                           grant
);

    logic [alu_cluster_pkg::XLEN-1:0]    op_a;
    logic [alu_cluster_pkg::XLEN-1:0]    op_b;
    logic [alu_cluster_pkg::SHAMT_W-1:0] shamt;
    logic [alu_cluster_pkg::XLEN-1:0]    alu_out;
    logic                                held;

    assign op_a  = issue_packet.rs1_data;
    assign op_b  = issue_packet.rs2_data;
    assign shamt = op_b[alu_cluster_pkg::SHAMT_W-1:0];

    ////////////////////////////////////////
    // Operation

    always_comb begin
        case (issue_packet.op)
            alu_cluster_pkg::ALU_ADD:  alu_out = op_a + op_b;
            alu_cluster_pkg::ALU_SUB:  alu_out = op_a - op_b;
            alu_cluster_pkg::ALU_AND:  alu_out = op_a & op_b;
            alu_cluster_pkg::ALU_OR:   alu_out = op_a | op_b;
            alu_cluster_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            alu_cluster_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_cluster_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
            alu_cluster_pkg::ALU_SLL:  alu_out = op_a << shamt;
            alu_cluster_pkg::ALU_SRL:  alu_out = op_a >> shamt;
            alu_cluster_pkg::ALU_SRA:  alu_out = $unsigned($signed(op_a) >>> shamt);
            default:                   alu_out = '0;
        endcase
    end

    ////////////////////////////////////////
    // Result hold

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            result.id   <= issue_packet.id;
            result.rd   <= issue_packet.rd;
            result.data <= alu_out;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= 1'b0;
        end else if (issue_valid) begin
            held <= 1'b1;
        end else if (grant) begin
            held <= 1'b0;
        end
    end

    // Single-cycle ALU, so the result is ready as soon as the lane is taken
    assign busy = held;
    assign done = held;

    ////////////////////////////////////////
    // Checks

    a_no_issue_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n) issue_valid |-> !busy
    );

    a_no_grant_without_done: assert property (
        @(posedge clk) disable iff (!rst_n) grant |-> done
    );

endmodule

/* rtl/writeback_arbiter.sv */
// Round-robin pick among finished ALU lanes, pushing the winner's result
// into the writeback buffer whenever that buffer has room.

`timescale 1ns/1ps

module writeback_arbiter (
    input  logic                                  clk,
    input  logic                                  rst_n,

    input  logic [alu_cluster_pkg::NUM_LANES-1:0] done,
    input  alu_cluster_pkg::wb_packet_t           results [alu_cluster_pkg::NUM_LANES],

    output logic [alu_cluster_pkg::NUM_LANES-1:0] grant,

    input  logic                                  space,
    output logic                                  push,
    output alu_cluster_pkg::wb_packet_t           push_data
);

    logic [alu_cluster_pkg::LANE_IDX_W-1:0] last_grant;
    logic [alu_cluster_pkg::LANE_IDX_W-1:0] sel;
    logic                                   sel_valid;

    ////////////////////////////////////////
    // Search order starts after last winner

    always_comb begin
        int idx;
        sel       = '0;
        sel_valid = 1'b0;
        for (int k = 1; k <= alu_cluster_pkg::NUM_LANES; k++) begin
            idx = (int'(last_grant) + k) % alu_cluster_pkg::NUM_LANES;
            if (done[idx] && !sel_valid) begin
                sel       = alu_cluster_pkg::LANE_IDX_W'(idx);
                sel_valid = 1'b1;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (sel_valid && space) begin
            grant[sel] = 1'b1;
        end
    end

    assign push      = sel_valid & space;
    assign push_data = results[sel];

    ////////////////////////////////////////
    // Priority pointer

    // Reset to the top lane so lane 0 wins first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_grant <= alu_cluster_pkg::LANE_IDX_W'(alu_cluster_pkg::NUM_LANES - 1);
        end else if (push) begin
            last_grant <= sel;
        end
    end

    ////////////////////////////////////////
    // Checks

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(grant)
    );

    // A lane that keeps its result gets served within one round
    a_grant_fair: assert property (
        @(posedge clk) disable iff (!rst_n)
        (done[0] && space) |-> ##[0:alu_cluster_pkg::NUM_LANES] (grant[0] || !space)
    );

endmodule

/* rtl/alu_cluster.sv */
// Top of the ALU cluster: issue buffer, dispatcher, parallel ALU lanes,
// writeback arbiter and output buffer, all with valid/ready handshakes.

`timescale 1ns/1ps

module alu_cluster (
    input  logic                           clk,
    input  logic                           rst_n,

    input  alu_cluster_pkg::issue_packet_t in_packet,
    input  logic                           in_valid,
    output logic                           in_ready,

    output alu_cluster_pkg::wb_packet_t    out_packet,
    output logic                           out_valid,
    input  logic                           out_ready
);

    // Issue path
    logic                                  in_push;
    alu_cluster_pkg::issue_packet_t        head;
    logic                                  head_valid;
    logic                                  head_pop;
    logic [alu_cluster_pkg::NUM_LANES-1:0] issue_valid;
    alu_cluster_pkg::issue_packet_t        issue_packet;

    // Lane handshakes
    logic [alu_cluster_pkg::NUM_LANES-1:0] busy;
    logic [alu_cluster_pkg::NUM_LANES-1:0] done;
    logic [alu_cluster_pkg::NUM_LANES-1:0] grant;
    alu_cluster_pkg::wb_packet_t           results [alu_cluster_pkg::NUM_LANES];

    // Writeback path
    logic                                  wb_push;
    logic                                  wb_space;
    alu_cluster_pkg::wb_packet_t           wb_data;
    logic                                  out_pop;

    assign in_push = in_valid & in_ready;
    assign out_pop = out_valid & out_ready;

    ////////////////////////////////////////
    // Issue buffer and dispatch

    packet_fifo #(.payload_t(alu_cluster_pkg::issue_packet_t)) in_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (in_push),
        .push_data  (in_packet),
        .push_ready (in_ready),
        .pop        (head_pop),
        .pop_data   (head),
        .pop_valid  (head_valid)
    );

    issue_dispatch dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .head         (head),
        .head_valid   (head_valid),
        .pop          (head_pop),
        .busy         (busy),
        .issue_valid  (issue_valid),
        .issue_packet (issue_packet)
    );

    ////////////////////////////////////////
    // ALU lanes

    for (genvar i = 0; i < alu_cluster_pkg::NUM_LANES; i++) begin : g_lane
        alu_lane lane (
            .clk          (clk),
            .rst_n        (rst_n),
            .issue_valid  (issue_valid[i]),
            .issue_packet (issue_packet),
            .busy         (busy[i]),
            .done         (done[i]),
            .result       (results[i]),
            .grant        (grant[i])
        );
    end

    ////////////////////////////////////////
    // Writeback

    writeback_arbiter wb_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .done      (done),
        .results   (results),
        .grant     (grant),
        .space     (wb_space),
        .push      (wb_push),
        .push_data (wb_data)
    );

    packet_fifo #(.payload_t(alu_cluster_pkg::wb_packet_t)) out_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (wb_push),
        .push_data  (wb_data),
        .push_ready (wb_space),
        .pop        (out_pop),
        .pop_data   (out_packet),
        .pop_valid  (out_valid)
    );

endmodule

/* verification/alu_cluster_tb.sv */
// Testbench for the ALU cluster. Runs the cases from verification/alu_cases.txt
// through the issue port and checks each writeback packet by its ID.

`timescale 1ns/1ps

module alu_cluster_tb;

    localparam int STALL_CASES = 14;

    logic                           clk;
    logic                           rst_n;
    alu_cluster_pkg::issue_packet_t in_packet;
    logic                           in_valid;
    logic                           in_ready;
    alu_cluster_pkg::wb_packet_t    out_packet;
    logic                           out_valid;
    logic                           out_ready;

    // Cases from the data file
    logic [3:0]  case_id  [$];
    logic [4:0]  case_rd  [$];
    logic [3:0]  case_op  [$];
    logic [31:0] case_a   [$];
    logic [31:0] case_b   [$];
    logic [31:0] case_exp [$];
    bit          cases_loaded;

    // Outstanding cases, indexed by ID
    bit pending  [];
    int pend_idx [];

    int errors;
    int tests_run;
    int tests_failed;
    int test_start;
    bit drain_done;
    bit stall_seen;

    alu_cluster uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_packet  (in_packet),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_packet (out_packet),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // Case file and scoreboard

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] t_id;
        logic [31:0] t_rd;
        logic [31:0] t_op;
        logic [31:0] t_a;
        logic [31:0] t_b;
        logic [31:0] t_exp;
        fd = $fopen("verification/alu_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file verification/alu_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Header and blank lines do not parse as six fields
                n = $sscanf(line, "%h %h %h %h %h %h", t_id, t_rd, t_op, t_a, t_b, t_exp);
                if (n == 6) begin
                    case_id.push_back(t_id[3:0]);
                    case_rd.push_back(t_rd[4:0]);
                    case_op.push_back(t_op[3:0]);
                    case_a.push_back(t_a);
                    case_b.push_back(t_b);
                    case_exp.push_back(t_exp);
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic void check_result(input alu_cluster_pkg::wb_packet_t pkt);
        int idx;
        if (!pending[pkt.id]) begin
            $display("Result with ID %0h came out but no case with that ID is outstanding",
                     pkt.id);
            errors++;
        end else begin
            idx = pend_idx[pkt.id];
            pending[pkt.id] = 1'b0;
            if (pkt.data !== case_exp[idx]) begin
                $display("mismatch out_packet.data case %0d id 0x%h: got 0x%08h expected 0x%08h",
                         idx, pkt.id, pkt.data, case_exp[idx]);
                errors++;
            end
            if (pkt.rd !== case_rd[idx]) begin
                $display("mismatch out_packet.rd case %0d id 0x%h: got 0x%02h expected 0x%02h",
                         idx, pkt.id, pkt.rd, case_rd[idx]);
                errors++;
            end
        end
    endfunction

    ////////////////////////////////////////
    // Drivers and monitor

    // Called 5 ns after a rising edge, returns at the same point
    task automatic issue_cases(input int first, input int last);
        bit accepted;
        for (int i = first; i <= last; i++) begin
            in_valid           = 1'b1;
            in_packet.id       = case_id[i];
            in_packet.rd       = case_rd[i];
            in_packet.op       = alu_cluster_pkg::alu_op_t'(case_op[i]);
            in_packet.rs1_data = case_a[i];
            in_packet.rs2_data = case_b[i];
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                if (in_ready) begin
                    accepted = 1'b1;
                    if (pending[case_id[i]]) begin
                        $display("ID %0h issued again while still outstanding", case_id[i]);
                        errors++;
                    end
                    pending[case_id[i]]  = 1'b1;
                    pend_idx[case_id[i]] = i;
                end
                @(posedge clk);
                #5;
            end
        end
        in_valid = 1'b0;
    endtask

    // Handshake is decided mid-cycle, the pop happens at the next edge
    task automatic collect_results(input int count);
        int got;
        got = 0;
        while (got < count) begin
            @(negedge clk);
            if (out_valid && out_ready) begin
                check_result(out_packet);
                got++;
            end
        end
    endtask

    task automatic toggle_out_ready();
        while (!drain_done) begin
            out_ready = ($urandom % 4) != 0;
            @(posedge clk);
            #5;
        end
        out_ready = 1'b1;
    endtask

    task automatic watch_stall();
        for (int n = 0; n < 40 && !stall_seen; n++) begin
            @(negedge clk);
            if (!in_ready) begin
                stall_seen = 1'b1;
            end
        end
        if (!stall_seen) begin
            $display("in_ready never dropped while out_ready was held low");
            errors++;
        end
        repeat (2) @(posedge clk);
        #5;
        out_ready = 1'b1;
    endtask

    task automatic end_test(input string name, input int start_errors);
        for (int id = 0; id < 16; id++) begin
            if (pending[id]) begin
                $display("Case %0d with ID %0h was issued but never came out", pend_idx[id], id);
                pending[id] = 1'b0;
                errors++;
            end
        end
        repeat (4) begin
            @(negedge clk);
            if (out_valid) begin
                $display("Extra result with ID %0h after all cases were delivered",
                         out_packet.id);
                errors++;
            end
        end
        tests_run++;
        if (errors != start_errors) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s, %0d errors", tests_run, name,
                 (errors == start_errors) ? "ok" : "FAILED", errors - start_errors);
        @(posedge clk);
        #5;
    endtask

    ////////////////////////////////////////
    // Test sequence

    initial begin
        void'($urandom(32'h76d12b08));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_packet    = '0;
        out_ready    = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        drain_done   = 1'b0;
        stall_seen   = 1'b0;
        pending      = new[16];
        pend_idx     = new[16];
        load_cases();
        cases_loaded = 1'b1;
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;

        if (case_exp.size() < STALL_CASES) begin
            $display("Case file holds %0d cases, at least %0d are needed",
                     case_exp.size(), STALL_CASES);
            errors++;
        end else begin
            test_start = errors;
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("mismatch out_valid after reset: got 0x%h expected 0x0", out_valid);
                errors++;
            end
            if (in_ready !== 1'b1) begin
                $display("mismatch in_ready after reset: got 0x%h expected 0x1", in_ready);
                errors++;
            end
            end_test("reset state", test_start);

            // One case at a time
            test_start = errors;
            for (int i = 0; i < case_exp.size(); i++) begin
                issue_cases(i, i);
                collect_results(1);
                @(posedge clk);
                #5;
            end
            end_test("alu operations", test_start);

            test_start = errors;
            fork
                issue_cases(0, case_exp.size() - 1);
                collect_results(case_exp.size());
            join
            end_test("back-to-back delivery", test_start);

            test_start = errors;
            drain_done = 1'b0;
            fork
                issue_cases(0, case_exp.size() - 1);
                begin
                    collect_results(case_exp.size());
                    drain_done = 1'b1;
                end
                toggle_out_ready();
            join
            end_test("random back-pressure", test_start);

            test_start = errors;
            out_ready  = 1'b0;
            stall_seen = 1'b0;
            fork
                issue_cases(0, STALL_CASES - 1);
                collect_results(STALL_CASES);
                watch_stall();
            join
            end_test("full stall", test_start);
        end

        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog, sized from the number of cases
    initial begin
        wait (cases_loaded);
        repeat (case_exp.size() * 40 + 200) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

/* verification/alu_cases.txt */
# Columns: id rd op rs1 rs2 expected, all hex
# op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 6 sltu, 7 sll, 8 srl, 9 sra
0 01 0 00000005 00000007 0000000c
1 02 0 ffffffff 00000001 00000000
2 03 0 7fffffff 00000001 80000000
3 04 1 0000000a 00000003 00000007
4 05 1 00000000 00000001 ffffffff
5 06 1 80000000 00000001 7fffffff
6 07 2 f0f0f0f0 ff00ff00 f000f000
7 08 2 12345678 0000ffff 00005678
8 09 3 f0f0f0f0 0f0f0f0f ffffffff
9 0a 3 12340000 00005678 12345678
a 0b 4 ffffffff 12345678 edcba987
b 0c 4 aaaaaaaa aaaaaaaa 00000000
c 0d 5 ffffffff 00000001 00000001
d 0e 5 00000001 ffffffff 00000000
e 0f 5 80000000 7fffffff 00000001
f 10 5 00000005 00000005 00000000
0 11 6 ffffffff 00000001 00000000
1 12 6 00000001 ffffffff 00000001
2 13 6 00000000 00000000 00000000
3 14 6 7fffffff 80000000 00000001
4 15 7 00000001 0000001f 80000000
5 16 7 12345678 00000004 23456780
6 17 7 00000001 00000021 00000002
7 18 7 ffffffff 00000000 ffffffff
8 19 8 80000000 0000001f 00000001
9 1a 8 12345678 00000008 00123456
a 1b 8 f0000000 00000024 0f000000
b 1c 9 80000000 0000001f ffffffff
c 1d 9 f0000000 00000004 ff000000
d 1e 9 7ffffff0 00000004 07ffffff
e 1f 9 87654321 00000008 ff876543
f 00 9 ffffff00 00000028 ffffffff
0 01 0 deadbeef 21524111 00000000
1 02 1 00000003 00000005 fffffffe
2 03 2 ffffffff 00000000 00000000
3 04 4 0000ffff ffff0000 ffffffff

/* project.f */
rtl/alu_cluster_pkg.sv
rtl/packet_fifo.sv
rtl/issue_dispatch.sv
rtl/alu_lane.sv
rtl/writeback_arbiter.sv
rtl/alu_cluster.sv
verification/alu_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the ALU cluster testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module alu_cluster_tb \
    -f project.f -o alu_cluster_sim \
    && ./obj_dir/alu_cluster_sim > sim.log 2>&1 \
    || echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null

grep -q "All tests passed!" sim.log 2>/dev/null \
    && { echo "Simulation PASSED"; exit 0; } \
    || { echo "Simulation FAILED"; exit 1; }
